//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Instruction type codes, bits [31:29]
// Code 3'b000 and codes above 3'b011 are unknown and decode as a bubble
`define R_TYPE_OP 3'b001
`define M_TYPE_OP 3'b010
`define B_TYPE_OP 3'b011

// Memory opcodes, bits [28:27] of an M type word
`define ISA_LDW_OP 2'b00
`define ISA_STW_OP 2'b01

// Branch opcodes, bits [28:27] of a B type word
`define ISA_BEQ_OP 2'b00

// ALU operation codes, also the func field of an R type word
`define ALU_ADD_OP 2'b00
`define ALU_SUB_OP 2'b01
`define ALU_AND_OP 2'b10
`define ALU_OR_OP  2'b11

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

`endif

//--- cpu_pkg.sv
package cpu_pkg;

    // Register format
    typedef struct packed {
        logic [2:0] type_code;
        logic [1:0] opcode;
        logic [1:0] func;
        logic [4:0] dst;
        logic [4:0] src1;
        logic [4:0] src2;
        logic [9:0] unused;
    } r_instr_t;

    // Memory format, dst holds the store data register for a store
    typedef struct packed {
        logic [2:0]  type_code;
        logic [1:0]  opcode;
        logic [1:0]  unused;
        logic [4:0]  dst;
        logic [4:0]  src1;
        logic [14:0] offset;
    } m_instr_t;

    // Branch format, offset split around the source fields
    typedef struct packed {
        logic [2:0] type_code;
        logic [1:0] opcode;
        logic [1:0] unused;
        logic [4:0] offset_high;
        logic [4:0] src1;
        logic [4:0] src2;
        logic [9:0] offset_low;
    } b_instr_t;

    typedef union packed {
        r_instr_t r_instr;
        m_instr_t m_instr;
        b_instr_t b_instr;
    } instr_u;

    typedef struct packed {
        logic        valid;
        instr_u      instr;
        logic [31:0] next_pc;
    } fetch_to_decode_t;

    typedef struct packed {
        logic [1:0] alu_op;
        logic       use_reg_b;
    } exec_ctrl_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic branch;
    } commit_ctrl_t;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
    } wb_ctrl_t;

    typedef struct packed {
        logic         valid;
        logic [31:0]  next_pc;
        logic [31:0]  ra_data;
        logic [31:0]  rb_data;
        logic [31:0]  offset_data;
        logic [4:0]   reg_dest;
        exec_ctrl_t   exec_ctrl;
        commit_ctrl_t commit_ctrl;
        wb_ctrl_t     wb_ctrl;
    } decode_to_exec_t;

    typedef struct packed {
        logic         valid;
        logic [31:0]  alu_result;
        logic [31:0]  store_data;
        logic [4:0]   reg_dest;
        commit_ctrl_t commit_ctrl;
        wb_ctrl_t     wb_ctrl;
    } exec_to_commit_t;

endpackage

//--- cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      redirect_valid,
    input  logic [31:0]               redirect_pc,
    input  cpu_pkg::instr_u           imem_data,
    output logic [31:0]               imem_addr,
    output cpu_pkg::fetch_to_decode_t fetch_out
);

    logic [31:0] pc;
    logic [31:0] pc_plus_4;

    assign imem_addr = pc;
    assign pc_plus_4 = pc + 32'd4;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= 32'd0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else begin
            pc <= pc_plus_4;
        end
    end

    // Word fetched this cycle is on the wrong path when execute redirects
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_out <= '0;
        end else begin
            fetch_out.valid   <= ~redirect_valid;
            fetch_out.instr   <= imem_data;
            fetch_out.next_pc <= pc_plus_4;
        end
    end

endmodule

//--- cpu_reg_bank.sv
`timescale 1ns/1ps

module cpu_reg_bank (
    input  logic        clock,
    input  logic        reset,
    input  logic [4:0]  read_reg_a,
    input  logic [4:0]  read_reg_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    input  logic        write_enable,
    input  logic [4:0]  write_reg,
    input  logic [31:0] write_data
);

    logic [31:0] regs [32];
    logic        write_live;

    // r0 is hardwired, so a write to it never lands
    assign write_live = write_enable && (write_reg != 5'd0);

    // Same-cycle write bypassed to both read ports
    assign read_data_a = (read_reg_a == 5'd0) ? 32'd0 :
                         (write_live && write_reg == read_reg_a) ? write_data :
                         regs[read_reg_a];
    assign read_data_b = (read_reg_b == 5'd0) ? 32'd0 :
                         (write_live && write_reg == read_reg_b) ? write_data :
                         regs[read_reg_b];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_live) begin
            regs[write_reg] <= write_data;
        end
    end

endmodule

//--- cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_decode (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      flush,
    input  cpu_pkg::fetch_to_decode_t fetch_in,
    output logic [4:0]                read_reg_a,
    output logic [4:0]                read_reg_b,
    input  logic [31:0]               read_data_a,
    input  logic [31:0]               read_data_b,
    output cpu_pkg::decode_to_exec_t  decode_out
);

    cpu_pkg::r_instr_t        r_word;
    cpu_pkg::m_instr_t        m_word;
    cpu_pkg::b_instr_t        b_word;
    cpu_pkg::decode_to_exec_t decode_next;
    logic                     is_store;
    logic                     known;

    assign r_word = fetch_in.instr.r_instr;
    assign m_word = fetch_in.instr.m_instr;
    assign b_word = fetch_in.instr.b_instr;

    assign is_store = (m_word.type_code == `M_TYPE_OP) && (m_word.opcode == `ISA_STW_OP);

    // src1 sits at the same bits in every format
    assign read_reg_a = r_word.src1;
    assign read_reg_b = is_store ? m_word.dst : r_word.src2;

    always_comb begin
        decode_next         = '0;
        known               = 1'b0;
        decode_next.next_pc = fetch_in.next_pc;
        decode_next.ra_data = read_data_a;
        decode_next.rb_data = read_data_b;
        decode_next.reg_dest = r_word.dst;

        case (r_word.type_code)
            `R_TYPE_OP: begin
                known                           = 1'b1;
                decode_next.exec_ctrl.alu_op    = r_word.func;
                decode_next.exec_ctrl.use_reg_b = 1'b1;
                decode_next.wb_ctrl.reg_write   = 1'b1;
            end
            `M_TYPE_OP: begin
                decode_next.exec_ctrl.alu_op = `ALU_ADD_OP;
                decode_next.offset_data      = {{17{m_word.offset[14]}}, m_word.offset};
                if (m_word.opcode == `ISA_LDW_OP) begin
                    known                            = 1'b1;
                    decode_next.commit_ctrl.mem_read = 1'b1;
                    decode_next.wb_ctrl.reg_write    = 1'b1;
                    decode_next.wb_ctrl.mem_to_reg   = 1'b1;
                end else if (m_word.opcode == `ISA_STW_OP) begin
                    known                             = 1'b1;
                    decode_next.commit_ctrl.mem_write = 1'b1;
                end
            end
            `B_TYPE_OP: begin
                if (b_word.opcode == `ISA_BEQ_OP) begin
                    known                           = 1'b1;
                    decode_next.exec_ctrl.alu_op    = `ALU_SUB_OP;
                    decode_next.exec_ctrl.use_reg_b = 1'b1;
                    decode_next.commit_ctrl.branch  = 1'b1;
                    decode_next.offset_data = {{17{b_word.offset_high[4]}},
                                               b_word.offset_high, b_word.offset_low};
                end
            end
            default: begin
                known = 1'b0;
            end
        endcase

        // Unknown words travel as bubbles
        decode_next.valid = fetch_in.valid && known && !flush;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            decode_out <= '0;
        end else begin
            decode_out <= decode_next;
        end
    end

endmodule

//--- cpu_execute.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_execute (
    input  logic                     clock,
    input  logic                     reset,
    input  cpu_pkg::decode_to_exec_t exec_in,
    output logic                     redirect_valid,
    output logic [31:0]              redirect_pc,
    output cpu_pkg::exec_to_commit_t exec_out
);

    logic [31:0] operand_b;
    logic [31:0] alu_result;

    assign operand_b = exec_in.exec_ctrl.use_reg_b ? exec_in.rb_data : exec_in.offset_data;

    always_comb begin
        case (exec_in.exec_ctrl.alu_op)
            `ALU_ADD_OP: alu_result = exec_in.ra_data + operand_b;
            `ALU_SUB_OP: alu_result = exec_in.ra_data - operand_b;
            `ALU_AND_OP: alu_result = exec_in.ra_data & operand_b;
            `ALU_OR_OP:  alu_result = exec_in.ra_data | operand_b;
            default:     alu_result = 32'd0;
        endcase
    end

    // Equal operands give a zero difference
    assign redirect_valid = exec_in.valid && exec_in.commit_ctrl.branch &&
                            (alu_result == 32'd0);
    assign redirect_pc    = exec_in.next_pc + {exec_in.offset_data[29:0], 2'b00};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exec_out <= '0;
        end else begin
            // A branch is finished here and goes no further
            exec_out.valid       <= exec_in.valid && !exec_in.commit_ctrl.branch;
            exec_out.alu_result  <= alu_result;
            exec_out.store_data  <= exec_in.rb_data;
            exec_out.reg_dest    <= exec_in.reg_dest;
            exec_out.commit_ctrl <= exec_in.commit_ctrl;
            exec_out.wb_ctrl     <= exec_in.wb_ctrl;
        end
    end

endmodule

//--- cpu_commit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_commit (
    input  logic                     clock,
    input  logic                     reset,
    input  cpu_pkg::exec_to_commit_t commit_in,
    output logic                     write_enable,
    output logic [4:0]               write_reg,
    output logic [31:0]              write_data,
    output logic                     wb_valid,
    output logic [4:0]               wb_reg,
    output logic [31:0]              wb_data,
    output logic                     store_valid,
    output logic [31:0]              store_addr,
    output logic [31:0]              store_data
);

    localparam int ADDR_BITS = $clog2(`DMEM_WORDS);

    logic [31:0]          dmem [`DMEM_WORDS];
    logic [ADDR_BITS-1:0] mem_index;
    logic [31:0]          load_word;

    // Word address, byte offset bits ignored
    assign mem_index = commit_in.alu_result[ADDR_BITS+1:2];
    assign load_word = commit_in.commit_ctrl.mem_read ? dmem[mem_index] : 32'd0;

    assign write_enable = commit_in.valid && commit_in.wb_ctrl.reg_write;
    assign write_reg    = commit_in.reg_dest;
    assign write_data   = commit_in.wb_ctrl.mem_to_reg ? load_word : commit_in.alu_result;

    assign wb_valid = write_enable;
    assign wb_reg   = write_reg;
    assign wb_data  = write_data;

    assign store_valid = commit_in.valid && commit_in.commit_ctrl.mem_write;
    assign store_addr  = commit_in.alu_result;
    assign store_data  = commit_in.store_data;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= 32'd0;
            end
        end else if (store_valid) begin
            dmem[mem_index] <= commit_in.store_data;
        end
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            clock,
    input  logic            reset,
    output logic [31:0]     imem_addr,
    input  cpu_pkg::instr_u imem_data,
    output logic            wb_valid,
    output logic [4:0]      wb_reg,
    output logic [31:0]     wb_data,
    output logic            store_valid,
    output logic [31:0]     store_addr,
    output logic [31:0]     store_data
);

    cpu_pkg::fetch_to_decode_t fetch_out;
    cpu_pkg::decode_to_exec_t  decode_out;
    cpu_pkg::exec_to_commit_t  exec_out;

    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [4:0]  read_reg_a;
    logic [4:0]  read_reg_b;
    logic [31:0] read_data_a;
    logic [31:0] read_data_b;
    logic        write_enable;
    logic [4:0]  write_reg;
    logic [31:0] write_data;

    cpu_fetch u_fetch (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .fetch_out      (fetch_out)
    );

    // Taken branch also squashes the word in decode
    cpu_decode u_decode (
        .clock       (clock),
        .reset       (reset),
        .flush       (redirect_valid),
        .fetch_in    (fetch_out),
        .read_reg_a  (read_reg_a),
        .read_reg_b  (read_reg_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .decode_out  (decode_out)
    );

    cpu_reg_bank u_reg_bank (
        .clock        (clock),
        .reset        (reset),
        .read_reg_a   (read_reg_a),
        .read_reg_b   (read_reg_b),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .write_enable (write_enable),
        .write_reg    (write_reg),
        .write_data   (write_data)
    );

    cpu_execute u_execute (
        .clock          (clock),
        .reset          (reset),
        .exec_in        (decode_out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exec_out       (exec_out)
    );

    cpu_commit u_commit (
        .clock        (clock),
        .reset        (reset),
        .commit_in    (exec_out),
        .write_enable (write_enable),
        .write_reg    (write_reg),
        .write_data   (write_data),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

endmodule

//--- cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
    input logic        clock,
    input logic        reset,
    input logic        wb_valid,
    input logic        store_valid,
    input logic        redirect_valid,
    input logic [31:0] redirect_pc,
    input logic [31:0] imem_addr,
    input logic [4:0]  read_reg_a,
    input logic [4:0]  read_reg_b,
    input logic [31:0] read_data_a,
    input logic [31:0] read_data_b
);

    int fail_count = 0;

    one_pulse_kind: assert property (@(posedge clock) disable iff (reset)
        !(wb_valid && store_valid))
        else begin
            fail_count++;
            $error("wb and store pulses in the same cycle");
        end

    quiet_in_reset: assert property (@(posedge clock)
        reset |-> !wb_valid && !store_valid && !redirect_valid)
        else begin
            fail_count++;
            $error("pulse seen while reset is high");
        end

    // Covers the first cycle after reset drops
    quiet_after_reset: assert property (@(posedge clock)
        reset |=> !wb_valid && !store_valid && !redirect_valid)
        else begin
            fail_count++;
            $error("pulse seen in the first cycle after reset");
        end

    reg0_reads_zero: assert property (@(posedge clock) disable iff (reset)
        (read_reg_a != 5'd0 || read_data_a == 32'd0) &&
        (read_reg_b != 5'd0 || read_data_b == 32'd0))
        else begin
            fail_count++;
            $error("register 0 read back nonzero");
        end

    redirect_target: assert property (@(posedge clock) disable iff (reset)
        redirect_valid |=> imem_addr == $past(redirect_pc))
        else begin
            fail_count++;
            $error("fetch did not follow the branch target");
        end

endmodule

bind cpu_top cpu_assertions u_asserts (
    .clock(clock), .reset(reset), .wb_valid(wb_valid), .store_valid(store_valid),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .imem_addr(imem_addr),
    .read_reg_a(read_reg_a), .read_reg_b(read_reg_b),
    .read_data_a(read_data_a), .read_data_b(read_data_b)
);

//--- tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu_top;

    typedef struct packed {
        logic        is_store;
        logic [4:0]  reg_num;
        logic [31:0] addr;
        logic [31:0] data;
    } pulse_t;

    logic            clock;
    logic            reset;
    logic [31:0]     imem_addr;
    cpu_pkg::instr_u imem_data;
    logic            wb_valid;
    logic [4:0]      wb_reg;
    logic [31:0]     wb_data;
    logic            store_valid;
    logic [31:0]     store_addr;
    logic [31:0]     store_data;

    cpu_pkg::instr_u imem [256];
    logic [31:0]     ref_regs [32];
    logic [31:0]     ref_mem [`DMEM_WORDS];
    logic [31:0]     init_words [8];
    pulse_t          expected [$];
    integer          seed;
    int              prog_len;
    int              errors;
    int              tests_run;
    int              pulses_seen;
    int              cycle_count;
    int              first_pulse_cycle;
    time             deadline;

    cpu_top u_dut (.*);

    // Instruction memory answers in the same cycle
    assign imem_data = imem[imem_addr[9:2]];

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(negedge clock) begin
        pulse_t p;
        if (reset) begin
            cycle_count = 0;
            assert (!wb_valid && !store_valid)
            else begin
                $display("Pulse seen during reset at %0t", $time);
                errors++;
            end
        end else begin
            if (wb_valid || store_valid) begin
                pulses_seen++;
                if (first_pulse_cycle < 0) first_pulse_cycle = cycle_count;
                if (expected.size() == 0) begin
                    $display("Pulse at %0t with nothing expected", $time);
                    errors++;
                end else begin
                    p = expected.pop_front();
                    check_value("store_valid", p.is_store, store_valid);
                    if (p.is_store) begin
                        check_value("store_addr", p.addr, store_addr);
                        check_value("store_data", p.data, store_data);
                    end else begin
                        check_value("wb_reg", p.reg_num, wb_reg);
                        check_value("wb_data", p.data, wb_data);
                    end
                end
            end
            cycle_count++;
        end
    end

    initial begin
        wait (deadline != 0);
        forever begin
            @(posedge clock);
            if ($time > deadline) begin
                $display("Timeout: expected pulses never arrived");
                $display("Simulation FAILED");
                $finish;
            end
        end
    end

    task automatic clear_program();
        for (int i = 0; i < 256; i++) imem[i] = {3'b000, 29'(i)};
        prog_len = 0;
    endtask

    task automatic put_r(input logic [1:0] func, input logic [4:0] dst, src1, src2);
        imem[prog_len].r_instr = '{type_code: `R_TYPE_OP, opcode: 2'b00, func: func,
                                   dst: dst, src1: src1, src2: src2, unused: 10'd0};
        prog_len++;
    endtask

    task automatic put_m(input logic [1:0] op, input logic [4:0] dst, src1, input int off);
        imem[prog_len].m_instr = '{type_code: `M_TYPE_OP, opcode: op, unused: 2'b00,
                                   dst: dst, src1: src1, offset: off[14:0]};
        prog_len++;
    endtask

    task automatic put_b(input logic [4:0] src1, src2, input int off);
        logic [14:0] o;
        o = off[14:0];
        imem[prog_len].b_instr = '{type_code: `B_TYPE_OP, opcode: `ISA_BEQ_OP, unused: 2'b00,
                                   offset_high: o[14:10], src1: src1, src2: src2,
                                   offset_low: o[9:0]};
        prog_len++;
    endtask

    task automatic put_raw(input logic [31:0] bits);
        imem[prog_len] = bits;
        prog_len++;
    endtask

    // Program order reference, squashed words never execute here
    task automatic run_model();
        cpu_pkg::instr_u w;
        logic [31:0] pc, a, b, off, res;
        pulse_t p;
        int steps;
        pc = 0;
        steps = 0;
        for (int i = 0; i < 32; i++) ref_regs[i] = 32'd0;
        for (int i = 0; i < `DMEM_WORDS; i++) ref_mem[i] = (i < 8) ? init_words[i] : 32'd0;
        while (pc[31:2] < prog_len && steps < 200) begin
            w = imem[pc[9:2]];
            a = ref_regs[w.r_instr.src1];
            b = ref_regs[w.r_instr.src2];
            p = '0;
            pc = pc + 4;
            steps++;
            if (w.r_instr.type_code == `R_TYPE_OP) begin
                case (w.r_instr.func)
                    `ALU_ADD_OP: res = a + b;
                    `ALU_SUB_OP: res = a - b;
                    `ALU_AND_OP: res = a & b;
                    default:     res = a | b;
                endcase
                p.reg_num = w.r_instr.dst;
                p.data = res;
                expected.push_back(p);
                if (p.reg_num != 0) ref_regs[p.reg_num] = res;
            end else if (w.m_instr.type_code == `M_TYPE_OP) begin
                off = {{17{w.m_instr.offset[14]}}, w.m_instr.offset};
                p.addr = a + off;
                p.reg_num = w.m_instr.dst;
                if (w.m_instr.opcode == `ISA_LDW_OP) begin
                    p.data = ref_mem[p.addr[7:2]];
                    expected.push_back(p);
                    if (p.reg_num != 0) ref_regs[p.reg_num] = p.data;
                end else if (w.m_instr.opcode == `ISA_STW_OP) begin
                    p.is_store = 1'b1;
                    p.data = ref_regs[p.reg_num];
                    expected.push_back(p);
                    ref_mem[p.addr[7:2]] = p.data;
                end
            end else if (w.b_instr.type_code == `B_TYPE_OP && w.b_instr.opcode == `ISA_BEQ_OP) begin
                off = {{17{w.b_instr.offset_high[4]}}, w.b_instr.offset_high,
                       w.b_instr.offset_low};
                if (a == b) pc = pc + (off << 2);
            end
        end
    endtask

    task automatic run_test(input string name);
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 8; i++) init_words[i] = $random(seed);
        run_model();
        first_pulse_cycle = -1;
        deadline = $time + (40 * prog_len + 200) * 4;
        reset = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 8; i++) u_dut.u_commit.dmem[i] = init_words[i];
        while (expected.size() != 0) @(posedge clock);
        // Let any stray pulse from the tail of the program show up
        repeat (8) @(posedge clock);
        check_value("first pulse cycle", 32'd3, first_pulse_cycle);
        tests_run++;
        $display("Test %s finished with %0d errors", name, errors - errors_before);
        #1;
    endtask

    initial begin
        seed = 32'h81a5c927;
        reset = 1'b1;
        errors = 0;
        tests_run = 0;
        pulses_seen = 0;
        deadline = 0;
        clear_program();

        put_m(`ISA_LDW_OP, 1, 0, 0);
        put_m(`ISA_LDW_OP, 2, 0, 4);
        put_m(`ISA_LDW_OP, 3, 0, 8);
        put_r(`ALU_ADD_OP, 4, 1, 2);
        put_r(`ALU_SUB_OP, 5, 1, 2);
        put_r(`ALU_AND_OP, 6, 1, 3);
        put_r(`ALU_OR_OP, 7, 2, 3);
        run_test("alu_ops");

        clear_program();
        put_m(`ISA_LDW_OP, 1, 0, 0);
        put_m(`ISA_LDW_OP, 2, 0, 4);
        put_m(`ISA_STW_OP, 1, 0, 20);
        put_r(`ALU_ADD_OP, 3, 1, 2);
        put_m(`ISA_LDW_OP, 5, 0, 20);
        put_m(`ISA_STW_OP, 3, 0, 16);
        put_m(`ISA_LDW_OP, 4, 0, 16);
        run_test("store_load");

        clear_program();
        put_m(`ISA_LDW_OP, 1, 0, 0);
        put_m(`ISA_LDW_OP, 2, 0, 0);
        put_m(`ISA_LDW_OP, 3, 0, 4);
        put_b(1, 2, 3);
        put_r(`ALU_ADD_OP, 4, 1, 1);
        put_r(`ALU_ADD_OP, 5, 1, 1);
        put_r(`ALU_ADD_OP, 6, 1, 1);
        put_r(`ALU_OR_OP, 7, 1, 3);
        put_b(1, 3, 5);
        put_b(9, 10, 2);
        put_r(`ALU_AND_OP, 8, 1, 3);
        put_r(`ALU_AND_OP, 8, 2, 3);
        put_r(`ALU_SUB_OP, 11, 1, 3);
        put_b(0, 0, 3);
        put_r(`ALU_ADD_OP, 12, 3, 3);
        put_r(`ALU_ADD_OP, 12, 1, 3);
        put_m(`ISA_LDW_OP, 20, 0, 4);
        put_r(`ALU_ADD_OP, 13, 1, 1);
        put_b(20, 0, -3);
        put_r(`ALU_OR_OP, 14, 1, 2);
        put_r(`ALU_OR_OP, 15, 2, 3);
        run_test("branches");

        clear_program();
        put_m(`ISA_LDW_OP, 1, 0, 0);
        put_m(`ISA_LDW_OP, 2, 0, 4);
        put_m(`ISA_LDW_OP, 3, 0, 8);
        put_r(`ALU_ADD_OP, 0, 1, 2);
        put_r(`ALU_OR_OP, 4, 0, 1);
        put_m(`ISA_STW_OP, 0, 0, 24);
        run_test("register_zero");

        clear_program();
        put_m(`ISA_LDW_OP, 1, 0, 0);
        put_raw(32'he0a5_1234);
        put_raw(32'h0012_3456);
        put_r(`ALU_ADD_OP, 2, 1, 1);
        put_raw(32'h7800_0004);
        put_raw(32'h5008_0000);
        put_r(`ALU_SUB_OP, 3, 2, 1);
        run_test("unknown_types");

        errors += u_dut.u_asserts.fail_count;
        $display("Tests run %0d, pulses checked %0d, errors %0d", tests_run, pulses_seen, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- cpu_top.f
+incdir+.
cpu_pkg.sv
cpu_fetch.sv
cpu_reg_bank.sv
cpu_decode.sv
cpu_execute.sv
cpu_commit.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu_top.sv
